// ==== rtl/prng_pkg.sv ====
// Random generator shared types

package prng_pkg;

    // ==================================================
    // data types
    // ==================================================

    typedef logic [31:0] prng_word_t;           // one engine word, one ram word

    // xorshift locks up at zero, so a zero seed maps here
    localparam prng_word_t SEED_FALLBACK = 32'h2545f491;

    // ==================================================
    // control from the fsm to the datapath
    // ==================================================

    typedef struct packed {
        logic load;                             // take seed, clear address
        logic run;                              // step, write ram, advance address
    } gen_ctrl_t;

    // ==================================================
    // fsm states
    // ==================================================

    typedef enum logic [1:0] {
        IDLE = 2'd0,                            // waiting for start
        LOAD = 2'd1,                            // single seed cycle
        GEN  = 2'd2,                            // one word per cycle
        DONE = 2'd3                             // hold generated until clear
    } gen_state_t;

endpackage : prng_pkg

// ==== rtl/gen_fsm.sv ====
// Generation sequence FSM

`timescale 1ns/10ps

module gen_fsm
    import prng_pkg::*;
(
    input  logic      fpga_clk_50,
    input  logic      hps_fpga_reset_n,
    input  logic      start,                    // host level
    input  logic      fsm_clear,                // host level, wins over start
    input  logic      last,                     // final address from the counter
    output gen_ctrl_t ctrl,
    output logic      generated,
    output logic      led_start
);

    // ==================================================
    // state register
    // ==================================================

    gen_state_t state;
    gen_state_t state_next;

    always_comb begin
        state_next = state;                     // hold by default
        if (fsm_clear) begin
            state_next = IDLE;                  // clear beats everything
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state_next = LOAD;
                    end
                end
                LOAD: begin
                    state_next = GEN;           // one cycle only
                end
                GEN: begin
                    if (last) begin
                        state_next = DONE;      // last run cycle
                    end
                end
                DONE: begin
                    state_next = DONE;          // start alone never restarts
                end
                default: begin
                    state_next = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
        if (!hps_fpga_reset_n) begin
            state     <= IDLE;
            generated <= 1'b0;
        end else begin
            state     <= state_next;
            generated <= (state_next == DONE);  // rises on the done entry edge
        end
    end

    // ==================================================
    // decode
    // ==================================================

    assign ctrl.load = (state == LOAD);
    assign ctrl.run  = (state == GEN);
    assign led_start = (state == GEN);          // lit for the whole pass

    // load and run go to the counter and the engine, they must not overlap
    ctrl_exclusive_a : assert property (
        @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        !(ctrl.load && ctrl.run)
    );

    // status flop must track the state register
    generated_done_a : assert property (
        @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        generated |-> (state == DONE)
    );

endmodule : gen_fsm

// ==== rtl/word_counter.sv ====
// Write address counter

`timescale 1ns/10ps

module word_counter
    import prng_pkg::*;
#(
    parameter int ADDR_W = 15                   // log2 of the ram depth
) (
    input  logic              fpga_clk_50,
    input  logic              hps_fpga_reset_n,
    input  gen_ctrl_t         ctrl,
    output logic [ADDR_W-1:0] wr_addr,
    output logic              last
);

    // ==================================================
    // address register
    // ==================================================

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
        if (!hps_fpga_reset_n) begin
            wr_addr <= '0;
        end else if (ctrl.load) begin
            wr_addr <= '0;                      // new pass starts at word 0
        end else if (ctrl.run) begin
            wr_addr <= wr_addr + 1'b1;          // wraps after the last word
        end
    end

    assign last = &wr_addr;                     // all ones, final word

    // the pass ends on the last run edge, counter must come back to zero
    wrap_a : assert property (
        @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        (ctrl.run && last) |=> (wr_addr == '0)
    );

endmodule : word_counter

// ==== rtl/xorshift_core.sv ====
// Xorshift engine

`timescale 1ns/10ps

module xorshift_core
    import prng_pkg::*;
(
    input  logic       fpga_clk_50,
    input  logic       hps_fpga_reset_n,
    input  gen_ctrl_t  ctrl,
    input  prng_word_t seed,                    // sampled on load
    output prng_word_t next_word                // step of the current state
);

    // ==================================================
    // one xorshift32 step
    // ==================================================

    function automatic prng_word_t step(input prng_word_t x);
        prng_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ==================================================
    // engine state
    // ==================================================

    prng_word_t state;

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
        if (!hps_fpga_reset_n) begin
            state <= SEED_FALLBACK;             // never zero, even before a load
        end else if (ctrl.load) begin
            state <= (seed == '0) ? SEED_FALLBACK : seed;
        end else if (ctrl.run) begin
            state <= step(state);               // one word per run cycle
        end
    end

    assign next_word = step(state);             // word i is step^(i+1) of the seed

    // zero is a fixed point of the step and must never be reached
    state_nonzero_a : assert property (
        @(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        state != '0
    );

endmodule : xorshift_core

// ==== rtl/sample_ram.sv ====
// Capture word memory

`timescale 1ns/10ps

module sample_ram
    import prng_pkg::*;
#(
    parameter int ADDR_W = 15                   // 2^ADDR_W words
) (
    input  logic              fpga_clk_50,
    input  logic              we,               // run from the fsm
    input  logic [ADDR_W-1:0] wr_addr,
    input  prng_word_t        wr_data,
    input  logic [ADDR_W-1:0] read_addr,
    output prng_word_t        read_data
);

    localparam int DEPTH = 1 << ADDR_W;

    // ==================================================
    // storage
    // ==================================================

    prng_word_t mem [DEPTH];                    // block ram, no init

    // write port
    always_ff @(posedge fpga_clk_50) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge fpga_clk_50) begin
        read_data <= mem[read_addr];
    end

endmodule : sample_ram

// ==== rtl/heartbeat_blinker.sv ====
// Heartbeat LED divider

`timescale 1ns/10ps

module heartbeat_blinker #(
    parameter int HALF_PERIOD = 25000000        // clocks per led level
) (
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    output logic led_heartbeat
);

    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(HALF_PERIOD - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
        if (!hps_fpga_reset_n) begin
            count         <= '0;
            led_heartbeat <= 1'b0;              // dark out of reset
        end else if (count == CNT_MAX) begin
            count         <= '0;
            led_heartbeat <= ~led_heartbeat;    // toggle each half period
        end else begin
            count         <= count + 1'b1;
        end
    end

endmodule : heartbeat_blinker

// ==== rtl/prng_top.sv ====
// Random bit generator top

`timescale 1ns/10ps

module prng_top
    import prng_pkg::*;
#(
    parameter int ADDR_W      = 15,             // 2^15 x 32 = 2^20 bits
    parameter int HALF_PERIOD = 25000000        // 0.5 s at 50 MHz
) (
    input  logic              fpga_clk_50,
    input  logic              hps_fpga_reset_n,
    input  prng_word_t        seed,
    input  logic              start,
    input  logic              fsm_clear,
    input  logic [ADDR_W-1:0] read_addr,
    output prng_word_t        read_data,
    output logic              generated,
    output logic              led_start,
    output logic              led_heartbeat
);

    // ==================================================
    // internal wires
    // ==================================================

    gen_ctrl_t         ctrl;                    // fsm to datapath
    logic              last;                    // counter at final word
    logic [ADDR_W-1:0] wr_addr;
    prng_word_t        next_word;               // engine to ram

    // ==================================================
    // sequencing
    // ==================================================

    gen_fsm u_gen_fsm (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .start            (start),
        .fsm_clear        (fsm_clear),
        .last             (last),
        .ctrl             (ctrl),
        .generated        (generated),
        .led_start        (led_start)
    );

    word_counter #(
        .ADDR_W (ADDR_W)
    ) u_word_counter (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ctrl             (ctrl),
        .wr_addr          (wr_addr),
        .last             (last)
    );

    // ==================================================
    // datapath
    // ==================================================

    xorshift_core u_xorshift_core (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ctrl             (ctrl),
        .seed             (seed),
        .next_word        (next_word)
    );

    sample_ram #(
        .ADDR_W (ADDR_W)
    ) u_sample_ram (
        .fpga_clk_50 (fpga_clk_50),
        .we          (ctrl.run),                // write every gen cycle
        .wr_addr     (wr_addr),
        .wr_data     (next_word),
        .read_addr   (read_addr),
        .read_data   (read_data)
    );

    // board heartbeat, independent of the generator
    heartbeat_blinker #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_heartbeat_blinker (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .led_heartbeat    (led_heartbeat)
    );

endmodule : prng_top

// ==== verification/prng_top_tb.sv ====
// Generator testbench

`timescale 1ns/10ps

module prng_top_tb
    import prng_pkg::*;
();

    localparam int ADDR_W      = 6;
    localparam int HALF_PERIOD = 20;
    localparam int DEPTH       = 1 << ADDR_W;
    localparam int GEN_EDGES   = DEPTH + 2;     // drive edge to generated high
    localparam int WAIT_LIMIT  = 4 * DEPTH;     // bound for every wait loop

    logic              fpga_clk_50;
    logic              hps_fpga_reset_n;
    prng_word_t        seed;
    logic              start;
    logic              fsm_clear;
    logic [ADDR_W-1:0] read_addr;
    prng_word_t        read_data;
    logic              generated;
    logic              led_start;
    logic              led_heartbeat;

    logic [31:0] lfsr_state;                    // random source
    prng_word_t  exp_words [DEPTH];             // model of the ram contents
    int          order [DEPTH];                 // readback order
    int          edge_count = 0;                // edges since reset release
    int          check_count;
    int          error_count;
    int          test_count;
    int          bad_tests;
    int          test_err_base;

    prng_top #(
        .ADDR_W      (ADDR_W),
        .HALF_PERIOD (HALF_PERIOD)
    ) dut (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .seed             (seed),
        .start            (start),
        .fsm_clear        (fsm_clear),
        .read_addr        (read_addr),
        .read_data        (read_data),
        .generated        (generated),
        .led_start        (led_start),
        .led_heartbeat    (led_heartbeat)
    );

    always #20 fpga_clk_50 = ~fpga_clk_50;      // 40 ns period

    always @(posedge fpga_clk_50) begin
        if (hps_fpga_reset_n) begin
            edge_count <= edge_count + 1;       // counting edges of the divider
        end
    end

    // ==================================================
    // random source and reference model
    // ==================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];       // taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // one step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_seed(output prng_word_t value);
        draw_bits(32, value);
        if (value == '0) begin
            value = 32'h1;                      // keep it nonzero
        end
    endtask

    // xorshift written as bit slices
    function automatic prng_word_t model_step(input prng_word_t x);
        prng_word_t y;
        y = x ^ {x[18:0], 13'b0};
        y = y ^ {17'b0, y[31:17]};
        y = y ^ {y[26:0], 5'b0};
        return y;
    endfunction

    task automatic build_model(input prng_word_t s);
        prng_word_t x;
        x = (s == '0) ? SEED_FALLBACK : s;      // zero seed swapped out
        for (int i = 0; i < DEPTH; i++) begin
            x            = model_step(x);
            exp_words[i] = x;                   // word i is step^(i+1)
        end
    endtask

    // ==================================================
    // checks and reporting
    // ==================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic begin_test();
        test_err_base = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_err_base) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            bad_tests++;
            $display("test %0d %s: %0d errors", test_count, name,
                     error_count - test_err_base);
        end
    endtask

    // ==================================================
    // stimulus tasks
    // ==================================================

    task automatic run_pass(input prng_word_t s);
        int edges;
        int lit;
        bit seen;
        build_model(s);
        @(posedge fpga_clk_50);
        seed  <= s;
        start <= 1'b1;
        edges = 0;
        lit   = 0;
        seen  = 1'b0;
        while (!seen && edges < WAIT_LIMIT) begin
            @(posedge fpga_clk_50);
            edges++;
            @(negedge fpga_clk_50);             // outputs settled
            if (generated) begin
                seen = 1'b1;
            end else if (led_start) begin
                lit++;                          // gen cycles seen so far
            end
        end
        if (!seen) begin
            report_problem($sformatf("timeout, generated still low %0d edges after start",
                                     edges));
        end else begin
            check_value("generated latency", GEN_EDGES, edges);
            check_value("led_start cycles", DEPTH, lit);
            check_value("led_start", 32'h0, 32'(led_start));
        end
    endtask

    task automatic read_all();
        logic [31:0] r;
        int j;
        int tmp;
        for (int i = 0; i < DEPTH; i++) begin
            order[i] = i;
        end
        for (int i = DEPTH - 1; i > 0; i--) begin
            draw_bits(ADDR_W, r);               // shuffle the addresses
            j        = int'(r) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < DEPTH; k++) begin
            @(posedge fpga_clk_50);
            read_addr <= ADDR_W'(order[k]);
            @(posedge fpga_clk_50);             // ram samples the address
            @(negedge fpga_clk_50);
            check_value($sformatf("read_data[%0d]", order[k]), exp_words[order[k]],
                        read_data);
        end
    endtask

    task automatic hold_done(input int cycles);
        repeat (cycles) begin
            @(posedge fpga_clk_50);
            @(negedge fpga_clk_50);
            check_value("generated", 32'h1, 32'(generated)); // start still high
        end
    endtask

    task automatic clear_machine();
        @(posedge fpga_clk_50);
        fsm_clear <= 1'b1;
        @(posedge fpga_clk_50);                 // clear taken on this edge
        fsm_clear <= 1'b0;
        start     <= 1'b0;
        @(negedge fpga_clk_50);
        check_value("generated", 32'h0, 32'(generated));
        check_value("led_start", 32'h0, 32'(led_start));
    endtask

    task automatic check_heartbeat(input int samples, input int spacing);
        logic expected;
        for (int s = 0; s < samples; s++) begin
            repeat (spacing) @(posedge fpga_clk_50);
            @(negedge fpga_clk_50);
            expected = ((edge_count / HALF_PERIOD) % 2) == 1; // level per half period
            check_value("led_heartbeat", 32'(expected), 32'(led_heartbeat));
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================

    initial begin
        prng_word_t pass_seed;
        fpga_clk_50      = 1'b0;
        hps_fpga_reset_n = 1'b0;
        seed             = '0;
        start            = 1'b0;
        fsm_clear        = 1'b0;
        read_addr        = '0;
        lfsr_state       = 32'hbd2d;
        check_count      = 0;
        error_count      = 0;
        test_count       = 0;
        bad_tests        = 0;
        repeat (10) @(posedge fpga_clk_50);
        hps_fpga_reset_n <= 1'b1;

        begin_test();
        @(negedge fpga_clk_50);
        check_value("generated", 32'h0, 32'(generated));
        check_value("led_start", 32'h0, 32'(led_start));
        check_value("led_heartbeat", 32'h0, 32'(led_heartbeat));
        end_test("reset state");

        begin_test();
        draw_seed(pass_seed);
        run_pass(pass_seed);
        end_test("first pass timing");

        begin_test();
        read_all();
        end_test("first pass readback");

        begin_test();
        hold_done(8);
        clear_machine();
        draw_seed(pass_seed);
        run_pass(pass_seed);                    // overwrites every word
        read_all();
        end_test("clear and second pass");

        begin_test();
        clear_machine();
        run_pass(32'h0);
        read_all();
        end_test("zero seed fallback");

        begin_test();
        check_heartbeat(12, 7);                 // 7 against 20 sweeps the phase
        end_test("heartbeat");

        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 test_count, bad_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : prng_top_tb

// ==== flist.f ====
rtl/prng_pkg.sv
rtl/gen_fsm.sv
rtl/word_counter.sv
rtl/xorshift_core.sv
rtl/sample_ram.sv
rtl/heartbeat_blinker.sv
rtl/prng_top.sv
verification/prng_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module prng_top_tb -f flist.f -o prng_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build did not complete, see $BUILD_LOG"
    exit 1
fi

./obj_dir/prng_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi

exit 0
